// ==== tile_mem.f ====
+incdir+tests
logic/tile_geom_pkg.sv
logic/tile_regs_pkg.sv
logic/tile_scratchpad.sv
logic/row_sum_engine.sv
logic/tile_csr.sv
logic/tile_top.sv
tests/tile_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the tile testbench with Verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tile_tb -f tile_mem.f -o tile_sim \
  && ./obj_dir/tile_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "TB PASSED" sim.log || { echo "Pass line not found in sim.log"; exit 1; }
exit 0

// ==== tests/tile_tb_tasks.svh ====
// AXI4-Lite host tasks, value check and directed tests for the row-sum tile

task automatic check_value(string test, axil_data_t expected, axil_data_t actual);
  if (expected !== actual) begin
    $display("** Error: %s: expected 0x%08h, actual 0x%08h", test, expected, actual);
    $display("TB FAILED");
    $fatal(1);
  end
endtask

task automatic abort_on_timeout(string what);
  $display("Timeout: gave up waiting for %s", what);
  $display("TB FAILED");
  $fatal(1);
endtask

// Sixteen LFSR steps, one per bit of the element
task automatic next_elem(output elem_t e);
  int b;
  e = '0;
  for (b = 0; b < 16; b++) begin
    lfsr_q = lfsr_next(lfsr_q);
    e = {e[14:0], lfsr_q[0]};
  end
endtask

task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                          output axil_resp_t resp);
  int cycles;
  @(posedge clk);
  axil_req.awvalid <= 1'b1;
  axil_req.awaddr  <= addr;
  axil_req.wvalid  <= 1'b1;
  axil_req.wdata   <= data;
  axil_req.bready  <= 1'b1;
  cycles = 0;
  do begin
    @(negedge clk);
    cycles++;
    if (cycles > WAIT_LIMIT) abort_on_timeout("awready");
  end while (!axil_rsp.awready);
  check_value("wready with awready", 32'd1, axil_data_t'(axil_rsp.wready));
  @(posedge clk);
  axil_req.awvalid <= 1'b0;
  axil_req.wvalid  <= 1'b0;
  cycles = 0;
  do begin
    @(negedge clk);
    cycles++;
    if (cycles > WAIT_LIMIT) abort_on_timeout("bvalid");
  end while (!axil_rsp.bvalid);
  resp = axil_rsp.bresp;
  @(posedge clk);
  axil_req.bready <= 1'b0;
endtask

// Rready stays low for rstall cycles once rvalid is up
task automatic axil_read(input axil_addr_t addr, input int rstall,
                         output axil_data_t data, output axil_resp_t resp);
  int cycles;
  int i;
  @(posedge clk);
  axil_req.arvalid <= 1'b1;
  axil_req.araddr  <= addr;
  axil_req.rready  <= (rstall == 0);
  cycles = 0;
  do begin
    @(negedge clk);
    cycles++;
    if (cycles > WAIT_LIMIT) abort_on_timeout("arready");
  end while (!axil_rsp.arready);
  @(posedge clk);
  axil_req.arvalid <= 1'b0;
  cycles = 0;
  do begin
    @(negedge clk);
    cycles++;
    if (cycles > WAIT_LIMIT) abort_on_timeout("rvalid");
  end while (!axil_rsp.rvalid);
  data = axil_rsp.rdata;
  resp = axil_rsp.rresp;
  if (rstall > 0) begin
    for (i = 0; i < rstall; i++) begin
      @(negedge clk);
      check_value("rvalid held", 32'd1, axil_data_t'(axil_rsp.rvalid));
      check_value("rdata held", data, axil_rsp.rdata);
    end
    @(posedge clk);
    axil_req.rready <= 1'b1;
    @(negedge clk);
    check_value("rdata at rready", data, axil_rsp.rdata);
  end
  @(posedge clk);
  axil_req.rready <= 1'b0;
endtask

// Poll STATUS until done is set and busy is clear
task automatic wait_row_done();
  axil_data_t d;
  axil_resp_t resp;
  int         polls;
  polls = 0;
  do begin
    axil_read(REG_STATUS, 0, d, resp);
    check_value("status poll resp", axil_data_t'(RESP_OKAY), axil_data_t'(resp));
    polls++;
    if (polls > POLL_LIMIT) abort_on_timeout("done bit in STATUS");
  end while (!(d[STATUS_DONE_BIT] && !d[STATUS_BUSY_BIT]));
endtask

task automatic run_row(int r);
  axil_data_t d;
  axil_resp_t resp;
  axil_write(REG_ROW, axil_data_t'(r), resp);
  check_value("row write resp", axil_data_t'(RESP_OKAY), axil_data_t'(resp));
  axil_write(REG_CTRL, 32'd1, resp);
  check_value("start resp", axil_data_t'(RESP_OKAY), axil_data_t'(resp));
  wait_row_done();
  axil_read(REG_RESULT, 0, d, resp);
  check_value($sformatf("row %0d result", r), axil_data_t'(row_total(r)), d);
endtask

task automatic check_reset_state();
  axil_data_t d;
  axil_resp_t resp;
  @(negedge clk);
  check_value("reset handshakes", 32'd0,
              axil_data_t'({axil_rsp.awready, axil_rsp.wready, axil_rsp.bvalid,
                            axil_rsp.arready, axil_rsp.rvalid}));
  axil_read(REG_STATUS, 0, d, resp);
  check_value("reset status", 32'd0, d);
  check_value("reset status resp", axil_data_t'(RESP_OKAY), axil_data_t'(resp));
  axil_read(REG_RESULT, 0, d, resp);
  check_value("reset result", 32'd0, d);
  check_value("reset result resp", axil_data_t'(RESP_OKAY), axil_data_t'(resp));
endtask

task automatic mem_round_trip();
  int         r;
  int         c;
  elem_t      e;
  axil_data_t d;
  axil_resp_t resp;
  for (r = 0; r < ROWS; r++) begin
    for (c = 0; c < COLS; c++) begin
      next_elem(e);
      model[r][c] = e;
      axil_write(win_addr(r, c), axil_data_t'(e), resp);
      check_value("window write resp", axil_data_t'(RESP_OKAY), axil_data_t'(resp));
    end
  end
  for (r = 0; r < ROWS; r++) begin
    for (c = 0; c < COLS; c++) begin
      axil_read(win_addr(r, c), 0, d, resp);
      check_value($sformatf("window read r%0d c%0d", r, c), {16'h0000, model[r][c]}, d);
      check_value("window read resp", axil_data_t'(RESP_OKAY), axil_data_t'(resp));
    end
  end
endtask

task automatic row_sums();
  run_row(0);
  run_row(3);
  run_row(7);
endtask

task automatic sticky_done_restart();
  axil_data_t d;
  axil_resp_t resp;
  axil_read(REG_STATUS, 0, d, resp);
  check_value("sticky done first", 32'h2, d);
  axil_read(REG_STATUS, 0, d, resp);
  check_value("sticky done second", 32'h2, d);
  // New result must overwrite the one from row 7
  run_row(1);
endtask

task automatic error_responses();
  axil_data_t d;
  axil_resp_t resp;
  axil_read(12'h040, 0, d, resp);
  check_value("unmapped read resp", axil_data_t'(RESP_SLVERR), axil_data_t'(resp));
  axil_write(REG_ROW, 32'd4, resp);
  axil_write(REG_CTRL, 32'd1, resp);
  check_value("start resp", axil_data_t'(RESP_OKAY), axil_data_t'(resp));
  // Both land while the engine is still reading row 4
  axil_write(win_addr(2, 5), axil_data_t'(~model[2][5]), resp);
  check_value("busy window write resp", axil_data_t'(RESP_SLVERR), axil_data_t'(resp));
  axil_write(REG_CTRL, 32'd1, resp);
  check_value("busy start resp", axil_data_t'(RESP_SLVERR), axil_data_t'(resp));
  wait_row_done();
  axil_read(REG_RESULT, 0, d, resp);
  check_value("row 4 result", axil_data_t'(row_total(4)), d);
  axil_read(win_addr(2, 5), 0, d, resp);
  check_value("word after busy write", {16'h0000, model[2][5]}, d);
endtask

task automatic read_backpressure();
  axil_data_t d;
  axil_resp_t resp;
  axil_read(win_addr(5, 3), 6, d, resp);
  check_value("stalled read data", {16'h0000, model[5][3]}, d);
  check_value("stalled read resp", axil_data_t'(RESP_OKAY), axil_data_t'(resp));
  axil_read(win_addr(6, 0), 0, d, resp);
  check_value("read after stall", {16'h0000, model[6][0]}, d);
endtask

// ==== tests/tile_tb.sv ====
// Testbench for the row-sum tile, driving its AXI4-Lite port through directed tests
module tile_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import tile_geom_pkg::*;
  import tile_regs_pkg::*;

  // Cycle limit for one handshake, and STATUS reads per row run
  localparam int WAIT_LIMIT = 100;
  localparam int POLL_LIMIT = 20;

  logic        clk;
  logic        reset;
  axil_req_t   axil_req;
  axil_rsp_t   axil_rsp;
  logic [15:0] lfsr_q;

  // Expected grid contents
  elem_t model [ROWS][COLS];

  tile_top i_tile_top (
    .clk      (clk),
    .reset    (reset),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // Model sum of one row, each element zero-extended
  function automatic sum_t row_total(int r);
    sum_t total;
    int   c;
    total = '0;
    for (c = 0; c < COLS; c++) begin
      total = total + sum_t'(model[r][c]);
    end
    return total;
  endfunction

  // Window byte address of one element, row-major
  function automatic axil_addr_t win_addr(int r, int c);
    return MEM_BASE + axil_addr_t'((r * COLS + c) * 4);
  endfunction

  `include "tile_tb_tasks.svh"

  initial begin
    axil_req <= '0;
    reset    <= 1'b1;
    lfsr_q   = 16'd42;
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    check_reset_state();
    mem_round_trip();
    row_sums();
    sticky_done_restart();
    error_responses();
    read_backpressure();

    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== logic/tile_top.sv ====
// Row-sum accelerator tile joining the register block, engine and scratchpad
module tile_top (
  input  logic                     clk,
  input  logic                     reset,
  input  tile_regs_pkg::axil_req_t axil_req,
  output tile_regs_pkg::axil_rsp_t axil_rsp
);
  import tile_geom_pkg::*;

  logic     start;
  row_t     row_sel;
  logic     busy;
  logic     done_pulse;
  sum_t     sum;
  mem_req_t host_req;
  mem_req_t eng_req;
  mem_rsp_t mem_rsp;

  tile_csr i_csr (
    .clk        (clk),
    .reset      (reset),
    .axil_req   (axil_req),
    .axil_rsp   (axil_rsp),
    .start      (start),
    .row_sel    (row_sel),
    .busy       (busy),
    .done_pulse (done_pulse),
    .sum        (sum),
    .host_req   (host_req),
    .rsp        (mem_rsp)
  );

  row_sum_engine i_engine (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .row_sel    (row_sel),
    .eng_req    (eng_req),
    .rsp        (mem_rsp),
    .busy       (busy),
    .done_pulse (done_pulse),
    .sum        (sum)
  );

  // Engine requests take priority inside the scratchpad
  tile_scratchpad i_scratchpad (
    .clk      (clk),
    .reset    (reset),
    .host_req (host_req),
    .eng_req  (eng_req),
    .rsp      (mem_rsp)
  );

endmodule

// ==== logic/tile_csr.sv ====
// AXI4-Lite slave with control, status and result registers and a scratchpad window
module tile_csr (
  input  logic                     clk,
  input  logic                     reset,
  input  tile_regs_pkg::axil_req_t axil_req,
  output tile_regs_pkg::axil_rsp_t axil_rsp,
  output logic                     start,
  output tile_geom_pkg::row_t      row_sel,
  input  logic                     busy,
  input  logic                     done_pulse,
  input  tile_geom_pkg::sum_t      sum,
  output tile_geom_pkg::mem_req_t  host_req,
  input  tile_geom_pkg::mem_rsp_t  rsp
);
  import tile_geom_pkg::*;
  import tile_regs_pkg::*;

  typedef enum logic [1:0] {
    W_IDLE,
    W_WAIT,
    W_RESP
  } wr_state_t;

  typedef enum logic [1:0] {
    R_IDLE,
    R_MEM,
    R_WAIT,
    R_RESP
  } rd_state_t;

  wr_state_t  wr_state;
  rd_state_t  rd_state;
  logic       wr_fire;
  logic       rd_fire;
  logic       aw_win;
  logic       ar_win;
  logic       wr_err;
  logic       wr_mem;
  logic       start_q;
  logic       done_q;
  row_t       row_q;
  sum_t       result_q;
  axil_resp_t bresp_q;
  axil_resp_t rresp_q;
  axil_data_t rdata_q;
  axil_addr_t ar_addr_q;
  axil_data_t reg_rdata;
  logic       reg_hit;

  function automatic logic in_window(axil_addr_t a);
    return (a >= MEM_BASE) && (a < MEM_BASE + axil_addr_t'(DEPTH * 4));
  endfunction

  // Build a scratchpad request from a window address
  function automatic mem_req_t win_req(axil_addr_t a, logic rd, logic wr, elem_t d);
    axil_addr_t word;
    mem_req_t   req;
    word           = (a - MEM_BASE) >> 2;
    req.read_en    = rd;
    req.write_en   = wr;
    req.row        = row_t'(word / COLS);
    req.col        = col_t'(word % COLS);
    req.write_data = d;
    return req;
  endfunction

  assign aw_win = in_window(axil_req.awaddr);
  assign ar_win = in_window(axil_req.araddr);

  // Hold writes off while the read channel owns the memory port
  assign wr_fire = (wr_state == W_IDLE) && axil_req.awvalid && axil_req.wvalid
                   && (rd_state != R_MEM);
  assign rd_fire = (rd_state == R_IDLE) && axil_req.arvalid;
  assign wr_mem  = wr_fire && aw_win && !busy;

  always_comb begin
    wr_err = 1'b0;
    if (aw_win) begin
      wr_err = busy;
    end else begin
      unique case (axil_req.awaddr)
        REG_CTRL:                      wr_err = axil_req.wdata[CTRL_START_BIT] && busy;
        REG_ROW, REG_STATUS, REG_RESULT: wr_err = 1'b0;
        default:                       wr_err = 1'b1;
      endcase
    end
  end

  // Register read mux
  always_comb begin
    reg_hit   = 1'b1;
    reg_rdata = '0;
    unique case (axil_req.araddr)
      REG_CTRL:   reg_rdata[CTRL_START_BIT] = start_q;
      REG_STATUS: begin
        reg_rdata[STATUS_BUSY_BIT] = busy || start_q;
        reg_rdata[STATUS_DONE_BIT] = done_q;
      end
      REG_ROW:    reg_rdata = axil_data_t'(row_q);
      REG_RESULT: reg_rdata = axil_data_t'(result_q);
      default:    reg_hit = 1'b0;
    endcase
  end

  // Host memory port, read channel and write channel never overlap
  always_comb begin
    host_req = '0;
    if (rd_state == R_MEM && !busy) begin
      host_req = win_req(ar_addr_q, 1'b1, 1'b0, '0);
    end else if (wr_mem) begin
      host_req = win_req(axil_req.awaddr, 1'b0, 1'b1, elem_t'(axil_req.wdata));
    end
  end

  // Write channel and control registers
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_state <= W_IDLE;
      start_q  <= 1'b0;
      done_q   <= 1'b0;
      row_q    <= '0;
      result_q <= '0;
    end else begin
      start_q <= 1'b0;
      if (done_pulse) begin
        done_q   <= 1'b1;
        result_q <= sum;
      end
      unique case (wr_state)
        W_IDLE: begin
          if (wr_fire) begin
            wr_state <= wr_mem ? W_WAIT : W_RESP;
            if (!aw_win && !wr_err && axil_req.awaddr == REG_CTRL
                && axil_req.wdata[CTRL_START_BIT]) begin
              // New run clears the sticky done
              start_q <= 1'b1;
              done_q  <= 1'b0;
            end
            if (!aw_win && axil_req.awaddr == REG_ROW) begin
              row_q <= row_t'(axil_req.wdata);
            end
          end
        end
        W_WAIT: if (rsp.write_done) wr_state <= W_RESP;
        W_RESP: if (axil_req.bready) wr_state <= W_IDLE;
        default: wr_state <= W_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bresp_q <= wr_err ? RESP_SLVERR : RESP_OKAY;
    end
  end

  // Read channel
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_state <= R_IDLE;
    end else begin
      unique case (rd_state)
        R_IDLE:  if (rd_fire) rd_state <= ar_win ? R_MEM : R_RESP;
        R_MEM:   rd_state <= busy ? R_RESP : R_WAIT;
        R_WAIT:  if (rsp.read_done) rd_state <= R_RESP;
        R_RESP:  if (axil_req.rready) rd_state <= R_IDLE;
        default: rd_state <= R_IDLE;
      endcase
    end
  end

  // Read data stays put while rvalid waits for rready
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      ar_addr_q <= axil_req.araddr;
      rdata_q   <= reg_rdata;
      rresp_q   <= reg_hit ? RESP_OKAY : RESP_SLVERR;
    end else if (rd_state == R_MEM && busy) begin
      rdata_q <= '0;
      rresp_q <= RESP_SLVERR;
    end else if (rd_state == R_WAIT && rsp.read_done) begin
      rdata_q <= axil_data_t'(rsp.read_data);
      rresp_q <= RESP_OKAY;
    end
  end

  assign axil_rsp.awready = wr_fire;
  assign axil_rsp.wready  = wr_fire;
  assign axil_rsp.bvalid  = (wr_state == W_RESP);
  assign axil_rsp.bresp   = bresp_q;
  assign axil_rsp.arready = rd_fire;
  assign axil_rsp.rvalid  = (rd_state == R_RESP);
  assign axil_rsp.rdata   = rdata_q;
  assign axil_rsp.rresp   = rresp_q;

  assign start   = start_q;
  assign row_sel = row_q;

endmodule

// ==== logic/row_sum_engine.sv ====
// Row-sum engine that streams one grid row out of the scratchpad and adds it up
module row_sum_engine (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    start,
  input  tile_geom_pkg::row_t     row_sel,
  output tile_geom_pkg::mem_req_t eng_req,
  input  tile_geom_pkg::mem_rsp_t rsp,
  output logic                    busy,
  output logic                    done_pulse,
  output tile_geom_pkg::sum_t     sum
);
  import tile_geom_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    DRAIN
  } state_t;

  state_t state;
  row_t   row_q;
  col_t   col_q;
  col_t   read_cnt;
  sum_t   sum_q;
  logic   pend_q;
  logic   take;

  // One read per cycle while issuing, columns 0 to 7
  always_comb begin
    eng_req            = '0;
    eng_req.read_en    = (state == ISSUE);
    eng_req.row        = row_q;
    eng_req.col        = col_q;
  end

  // Only count read_done that answers one of our own reads
  assign take = pend_q && rsp.read_done;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= IDLE;
      col_q      <= '0;
      read_cnt   <= '0;
      pend_q     <= 1'b0;
      done_pulse <= 1'b0;
    end else begin
      pend_q     <= eng_req.read_en;
      done_pulse <= 1'b0;
      unique case (state)
        IDLE: begin
          if (start) begin
            state    <= ISSUE;
            col_q    <= '0;
            read_cnt <= '0;
          end
        end
        ISSUE: begin
          col_q <= col_q + 1'b1;
          if (col_q == LAST_COL) begin
            state <= DRAIN;
          end
        end
        DRAIN: begin
          // Eighth element arrived
          if (take && read_cnt == LAST_COL) begin
            state      <= IDLE;
            done_pulse <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
      if (take) begin
        read_cnt <= read_cnt + 1'b1;
      end
    end
  end

  // Row latch and accumulator
  always_ff @(posedge clk) begin
    if (state == IDLE && start) begin
      row_q <= row_sel;
      sum_q <= '0;
    end else if (take) begin
      sum_q <= sum_q + sum_t'(rsp.read_data);
    end
  end

  assign busy = (state != IDLE);
  assign sum  = sum_q;

  // The CSR block must drop a start while a row is in progress
  a_no_start_busy: assert property (
    @(posedge clk) disable iff (reset) start |-> !busy
  );

endmodule

// ==== logic/tile_scratchpad.sv ====
// Scratchpad of one-cycle sequential memory with engine-priority request select
module tile_scratchpad (
  input  logic                    clk,
  input  logic                    reset,
  input  tile_geom_pkg::mem_req_t host_req,
  input  tile_geom_pkg::mem_req_t eng_req,
  output tile_geom_pkg::mem_rsp_t rsp
);
  import tile_geom_pkg::*;

  mem_req_t sel_req;
  idx_t     idx;
  elem_t    mem [DEPTH];
  elem_t    read_q;
  logic     read_done_q;
  logic     write_done_q;
  logic     host_active;
  logic     eng_active;

  assign host_active = host_req.read_en || host_req.write_en;
  assign eng_active  = eng_req.read_en || eng_req.write_en;

  // Engine wins whenever it asks for anything
  assign sel_req = eng_active ? eng_req : host_req;

  // Row-major flattening
  assign idx = idx_t'(sel_req.row) * idx_t'(COLS) + idx_t'(sel_req.col);

  // Registered read port, clobbered by a write
  always_ff @(posedge clk) begin
    if (reset) begin
      read_q <= '0;
    end else if (sel_req.read_en) begin
      read_q <= mem[idx];
    end else if (sel_req.write_en) begin
      read_q <= 'x;
    end
  end

  always_ff @(posedge clk) begin
    if (sel_req.write_en) begin
      mem[idx] <= sel_req.write_data;
    end
  end

  // Done pulses, one cycle after the request
  always_ff @(posedge clk) begin
    if (reset) begin
      read_done_q  <= 1'b0;
      write_done_q <= 1'b0;
    end else begin
      read_done_q  <= sel_req.read_en;
      write_done_q <= sel_req.write_en;
    end
  end

  assign rsp = '{read_data: read_q, read_done: read_done_q, write_done: write_done_q};

  // Neither requester may ask for a read and a write at once
  a_no_rd_wr: assert property (
    @(posedge clk) disable iff (reset) !(sel_req.read_en && sel_req.write_en)
  );

  // The CSR block holds off the host while the engine runs
  a_no_overlap: assert property (
    @(posedge clk) disable iff (reset) !(host_active && eng_active)
  );

endmodule

// ==== logic/tile_regs_pkg.sv ====
// Register map, status bits and AXI4-Lite bus structs of the row-sum tile
package tile_regs_pkg;

  // Bus field types
  typedef logic [11:0] axil_addr_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [1:0]  axil_resp_t;

  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  // Register offsets
  localparam axil_addr_t REG_CTRL   = 12'h000;
  localparam axil_addr_t REG_STATUS = 12'h004;
  localparam axil_addr_t REG_ROW    = 12'h008;
  localparam axil_addr_t REG_RESULT = 12'h00C;

  // Scratchpad window, one word per element, row-major
  localparam axil_addr_t MEM_BASE = 12'h100;

  // CTRL bits (start is write-one, self-clearing)
  localparam int CTRL_START_BIT = 0;

  // STATUS bits
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;

  // Everything the host drives
  typedef struct packed {
    logic       awvalid;
    axil_addr_t awaddr;
    logic       wvalid;
    axil_data_t wdata;
    logic       bready;
    logic       arvalid;
    axil_addr_t araddr;
    logic       rready;
  } axil_req_t;

  // Everything the tile drives back
  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    axil_resp_t bresp;
    logic       arready;
    logic       rvalid;
    axil_data_t rdata;
    axil_resp_t rresp;
  } axil_rsp_t;

endpackage

// ==== logic/tile_geom_pkg.sv ====
// Grid geometry, element types and scratchpad request and response structs
package tile_geom_pkg;

  // Grid dimensions
  localparam int ROWS  = 8;
  localparam int COLS  = 8;
  localparam int DEPTH = ROWS * COLS;

  // One grid element
  typedef logic [15:0] elem_t;

  // Row and column indices
  typedef logic [$clog2(ROWS)-1:0] row_t;
  typedef logic [$clog2(COLS)-1:0] col_t;

  // Flattened row-major word index
  typedef logic [$clog2(DEPTH)-1:0] idx_t;

  // Accumulated row sum
  typedef logic [31:0] sum_t;

  localparam col_t LAST_COL = col_t'(COLS - 1);

  // One request to the scratchpad
  typedef struct packed {
    logic  read_en;
    logic  write_en;
    row_t  row;
    col_t  col;
    elem_t write_data;
  } mem_req_t;

  // Scratchpad answer, valid one cycle after the request
  typedef struct packed {
    elem_t read_data;
    logic  read_done;
    logic  write_done;
  } mem_rsp_t;

endpackage
